// ==== verilog/cache_geom_pkg.sv ====
package cache_geom_pkg;

    // Byte address and data widths.
    localparam int ADDR_W     = 32;
    localparam int LINE_W     = 64;
    localparam int INSN_W     = 32;

    // Two instructions per line, so three offset bits.
    localparam int LINE_OFF_W = 3;

    // Replacement ages.
    localparam int AGE_W      = 3;
    localparam int AGE_MAX    = 7;

    typedef logic [AGE_W-1:0]  age_t;
    typedef logic [LINE_W-1:0] line_t;

    // Lookup result of one way for the addressed set.
    typedef struct packed {
        logic  hit;
        logic  valid;
        line_t line;
    } way_result_t;

endpackage

// ==== verilog/fetch_bus_pkg.sv ====
package fetch_bus_pkg;

    import cache_geom_pkg::*;

    // Core side.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [INSN_W-1:0] insn;
    } fetch_rsp_t;

    // Memory side, one whole line per transfer.
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

endpackage

// ==== verilog/icache_sram.sv ====
`timescale 1ns/1ns

module icache_sram #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 64,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          i_we,
    input  logic [AW-1:0] i_addr,
    input  T              i_wdata,
    output T              o_rdata
);

    T mem [DEPTH];

    // Read-first, the old word comes out on a write.
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

// ==== verilog/icache_way.sv ====
`timescale 1ns/1ns

module icache_way
    import cache_geom_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = ADDR_W - LINE_OFF_W - IDX_W
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_flush,
    input  logic [IDX_W-1:0] i_index,
    input  logic [TAG_W-1:0] i_tag,
    input  logic             i_fill,
    input  line_t            i_fill_line,
    output way_result_t      o_result
);

    typedef logic [TAG_W-1:0] tag_t;

    tag_t                tag_rd;
    line_t               line_rd;
    tag_t                tag_cmp_q;
    logic                valid_rd_q;
    logic [NUM_SETS-1:0] valid_q;

    icache_sram #(
        .T     (tag_t),
        .DEPTH (NUM_SETS)
    ) u_tag_ram (
        .clk     (clk),
        .i_we    (i_fill),
        .i_addr  (i_index),
        .i_wdata (i_tag),
        .o_rdata (tag_rd)
    );

    icache_sram #(
        .T     (line_t),
        .DEPTH (NUM_SETS)
    ) u_line_ram (
        .clk     (clk),
        .i_we    (i_fill),
        .i_addr  (i_index),
        .i_wdata (i_fill_line),
        .o_rdata (line_rd)
    );

    // Compare tag follows the RAM read by one cycle.
    always_ff @(posedge clk) begin
        tag_cmp_q <= i_tag;
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q    <= '0;
            valid_rd_q <= 1'b0;
        end else begin
            valid_rd_q <= valid_q[i_index];
            if (i_flush) begin
                valid_q <= '0;
            end else if (i_fill) begin
                valid_q[i_index] <= 1'b1;
            end
        end
    end

    assign o_result.hit   = valid_rd_q && (tag_rd == tag_cmp_q);
    assign o_result.valid = valid_rd_q;
    assign o_result.line  = line_rd;

    // Flush only comes while the controller is idle.
    a_fill_flush: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_fill && i_flush));

endmodule

// ==== verilog/icache_age.sv ====
`timescale 1ns/1ns

module icache_age
    import cache_geom_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic             clk,
    input  logic             i_rst_n,
    input  logic             i_accept,
    input  logic [IDX_W-1:0] i_set,
    input  logic             i_touch0,
    input  logic             i_touch1,
    input  logic             i_valid0,
    input  logic             i_valid1,
    output logic             o_victim
);

    age_t age0_q [NUM_SETS];
    age_t age1_q [NUM_SETS];
    logic pending_q;

    function automatic age_t age_inc(input age_t a);
        return (a == age_t'(AGE_MAX)) ? a : a + age_t'(1);
    endfunction

    // Clear beats increment on the same entry.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                age0_q[s] <= '0;
                age1_q[s] <= '0;
            end
        end else begin
            for (int s = 0; s < NUM_SETS; s++) begin
                if (i_touch0 && i_set == IDX_W'(s)) begin
                    age0_q[s] <= '0;
                end else if (i_accept) begin
                    age0_q[s] <= age_inc(age0_q[s]);
                end
                if (i_touch1 && i_set == IDX_W'(s)) begin
                    age1_q[s] <= '0;
                end else if (i_accept) begin
                    age1_q[s] <= age_inc(age1_q[s]);
                end
            end
        end
    end

    // Invalid way first, then the older one, tie to way 0.
    always_comb begin
        if (!i_valid0) begin
            o_victim = 1'b0;
        end else if (!i_valid1) begin
            o_victim = 1'b1;
        end else begin
            o_victim = age1_q[i_set] > age0_q[i_set];
        end
    end

    // One touch per accepted request.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pending_q <= 1'b0;
        end else if (i_accept) begin
            pending_q <= 1'b1;
        end else if (i_touch0 || i_touch1) begin
            pending_q <= 1'b0;
        end
    end

    a_touch_in_flight: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_touch0 || i_touch1) |-> pending_q && !(i_touch0 && i_touch1));

endmodule

// ==== verilog/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl
    import cache_geom_pkg::*;
    import fetch_bus_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = ADDR_W - LINE_OFF_W - IDX_W
) (
    input  logic             clk,
    input  logic             i_rst_n,

    input  logic             i_req,
    input  fetch_req_t       i_req_addr,
    output logic             o_rsp,
    output fetch_rsp_t       o_rsp_data,

    output logic             o_mem_req,
    output mem_req_t         o_mem_req_addr,
    input  logic             i_mem_rsp,
    input  mem_rsp_t         i_mem_rsp_data,

    input  way_result_t      i_res0,
    input  way_result_t      i_res1,
    output logic [IDX_W-1:0] o_index,
    output logic [TAG_W-1:0] o_tag,
    output logic             o_fill0,
    output logic             o_fill1,
    output line_t            o_fill_line,

    output logic             o_accept,
    output logic             o_touch0,
    output logic             o_touch1,
    input  logic             i_victim
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WAIT,
        S_RESP
    } state_t;

    state_t     state_q;
    state_t     state_d;
    fetch_req_t addr_q;
    fetch_rsp_t rsp_data_q;
    logic       mem_req_q;
    logic       victim_q;

    logic       accept;
    logic       lookup;
    logic       hit_any;
    logic       fill_any;
    logic       word_sel;
    line_t      hit_line;
    fetch_req_t cur_addr;

    function automatic logic [INSN_W-1:0] pick_insn(input line_t line, input logic sel);
        return sel ? line[LINE_W-1:INSN_W] : line[INSN_W-1:0];
    endfunction

    assign accept   = i_req && (state_q == S_IDLE);
    assign lookup   = (state_q == S_LOOKUP);
    assign hit_any  = i_res0.hit || i_res1.hit;
    assign hit_line = i_res0.hit ? i_res0.line : i_res1.line;
    assign fill_any = (state_q == S_WAIT) && i_mem_rsp;
    assign word_sel = addr_q.addr[LINE_OFF_W-1];

    // New address goes straight to the RAMs in the accept cycle.
    assign cur_addr = (state_q == S_IDLE) ? i_req_addr : addr_q;
    assign o_index  = cur_addr.addr[LINE_OFF_W +: IDX_W];
    assign o_tag    = cur_addr.addr[ADDR_W-1 -: TAG_W];

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (i_req) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                state_d = hit_any ? S_RESP : S_WAIT;
            end
            S_WAIT: begin
                if (i_mem_rsp) begin
                    state_d = S_RESP;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= S_IDLE;
            mem_req_q <= 1'b0;
            victim_q  <= 1'b0;
        end else begin
            state_q   <= state_d;
            mem_req_q <= lookup && !hit_any;
            // Victim is frozen at lookup for the fill.
            if (lookup && !hit_any) begin
                victim_q <= i_victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= i_req_addr;
        end
        if (lookup && hit_any) begin
            rsp_data_q.insn <= pick_insn(hit_line, word_sel);
        end else if (fill_any) begin
            rsp_data_q.insn <= pick_insn(i_mem_rsp_data.line, word_sel);
        end
    end

    assign o_rsp      = (state_q == S_RESP);
    assign o_rsp_data = rsp_data_q;

    assign o_mem_req           = mem_req_q;
    assign o_mem_req_addr.addr = {addr_q.addr[ADDR_W-1:LINE_OFF_W], LINE_OFF_W'(0)};

    assign o_fill0     = fill_any && !victim_q;
    assign o_fill1     = fill_any && victim_q;
    assign o_fill_line = i_mem_rsp_data.line;

    assign o_accept = accept;
    assign o_touch0 = (lookup && i_res0.hit) || o_fill0;
    assign o_touch1 = (lookup && i_res1.hit) || o_fill1;

    // The core waits for o_rsp before the next fetch.
    a_no_req_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_req |-> state_q == S_IDLE);

    // A line never lives in both ways.
    a_one_hit: assert property (@(posedge clk) disable iff (!i_rst_n)
        lookup |-> !(i_res0.hit && i_res1.hit));

endmodule

// ==== verilog/icache_top.sv ====
`timescale 1ns/1ns

module icache_top
    import cache_geom_pkg::*;
    import fetch_bus_pkg::*;
#(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS),
    localparam int TAG_W    = ADDR_W - LINE_OFF_W - IDX_W
) (
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_req,
    input  fetch_req_t i_req_addr,
    input  logic       i_flush,
    output logic       o_rsp,
    output fetch_rsp_t o_rsp_data,
    output logic       o_mem_req,
    output mem_req_t   o_mem_req_addr,
    input  logic       i_mem_rsp,
    input  mem_rsp_t   i_mem_rsp_data
);

    way_result_t      res0;
    way_result_t      res1;
    logic [IDX_W-1:0] index;
    logic [TAG_W-1:0] tag;
    logic             fill0;
    logic             fill1;
    line_t            fill_line;
    logic             accept;
    logic             touch0;
    logic             touch1;
    logic             victim;

    icache_way #(
        .NUM_SETS (NUM_SETS)
    ) u_way0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_index     (index),
        .i_tag       (tag),
        .i_fill      (fill0),
        .i_fill_line (fill_line),
        .o_result    (res0)
    );

    icache_way #(
        .NUM_SETS (NUM_SETS)
    ) u_way1 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_index     (index),
        .i_tag       (tag),
        .i_fill      (fill1),
        .i_fill_line (fill_line),
        .o_result    (res1)
    );

    icache_age #(
        .NUM_SETS (NUM_SETS)
    ) u_age (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_accept (accept),
        .i_set    (index),
        .i_touch0 (touch0),
        .i_touch1 (touch1),
        .i_valid0 (res0.valid),
        .i_valid1 (res1.valid),
        .o_victim (victim)
    );

    icache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_req          (i_req),
        .i_req_addr     (i_req_addr),
        .o_rsp          (o_rsp),
        .o_rsp_data     (o_rsp_data),
        .o_mem_req      (o_mem_req),
        .o_mem_req_addr (o_mem_req_addr),
        .i_mem_rsp      (i_mem_rsp),
        .i_mem_rsp_data (i_mem_rsp_data),
        .i_res0         (res0),
        .i_res1         (res1),
        .o_index        (index),
        .o_tag          (tag),
        .o_fill0        (fill0),
        .o_fill1        (fill1),
        .o_fill_line    (fill_line),
        .o_accept       (accept),
        .o_touch0       (touch0),
        .o_touch1       (touch1),
        .i_victim       (victim)
    );

endmodule

// ==== tests/tb_icache.sv ====
`timescale 1ns/1ns

module tb_icache
    import cache_geom_pkg::*;
    import fetch_bus_pkg::*;
();

    localparam int NUM_SETS   = 64;
    localparam int IDX_W      = $clog2(NUM_SETS);
    localparam int TAG_W      = ADDR_W - LINE_OFF_W - IDX_W;
    localparam int NUM_REQ    = 4 + 20 + 60 + 26;
    localparam int MAX_CYCLES = 12 * NUM_REQ + 200;

    logic       clk;
    logic       i_rst_n;
    logic       i_req;
    fetch_req_t i_req_addr;
    logic       i_flush;
    logic       o_rsp;
    fetch_rsp_t o_rsp_data;
    logic       o_mem_req;
    mem_req_t   o_mem_req_addr;
    logic       i_mem_rsp;
    mem_rsp_t   i_mem_rsp_data;

    int cyc = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int mem_delay = 1;
    int mem_rsp_cyc = -1;

    // Reference model state per set and way.
    logic [TAG_W-1:0] m_tag [NUM_SETS][2];
    bit               m_valid [NUM_SETS][2];
    int               m_age [NUM_SETS][2];

    icache_top #(
        .NUM_SETS (NUM_SETS)
    ) i_dut (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_req          (i_req),
        .i_req_addr     (i_req_addr),
        .i_flush        (i_flush),
        .o_rsp          (o_rsp),
        .o_rsp_data     (o_rsp_data),
        .o_mem_req      (o_mem_req),
        .o_mem_req_addr (o_mem_req_addr),
        .i_mem_rsp      (i_mem_rsp),
        .i_mem_rsp_data (i_mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Memory contents are a fixed function of the line address.
    function automatic line_t expected_line(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] a;
        a = {addr[ADDR_W-1:LINE_OFF_W], 3'b000};
        return {a ^ 32'hc001_d00d, {a[15:0], a[31:16]} + 32'h1357_9bdf};
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set, input bit word);
        return {TAG_W'(tag), IDX_W'(set), word, 2'b00};
    endfunction

    // Returns the predicted hit and updates tags, valids and ages.
    function automatic bit model_access(input logic [ADDR_W-1:0] addr);
        int               set;
        int               way;
        bit               hit;
        logic [TAG_W-1:0] tag;
        set = addr[LINE_OFF_W +: IDX_W];
        tag = addr[ADDR_W-1 -: TAG_W];
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_age[s][w] < AGE_MAX) begin
                    m_age[s][w]++;
                end
            end
        end
        hit = 1'b1;
        if (m_valid[set][0] && m_tag[set][0] == tag) begin
            way = 0;
        end else if (m_valid[set][1] && m_tag[set][1] == tag) begin
            way = 1;
        end else begin
            hit = 1'b0;
            if (!m_valid[set][0]) begin
                way = 0;
            end else if (!m_valid[set][1]) begin
                way = 1;
            end else begin
                way = (m_age[set][1] > m_age[set][0]) ? 1 : 0;
            end
            m_valid[set][way] = 1'b1;
            m_tag[set][way] = tag;
        end
        m_age[set][way] = 0;
        return hit;
    endfunction

    task automatic report_mismatch(input string test, input string what,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("Mismatch in %s, %s: expected %0h, actual %0h", test, what, exp, act);
        errors++;
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("Test %-12s %s, %0d errors", name,
                 (errors == err_start) ? "ok" : "failed", errors - err_start);
    endtask

    // Issues one fetch and checks data and hit or miss timing.
    task automatic fetch_and_check(input string test, input logic [ADDR_W-1:0] addr,
                                   output bit was_hit);
        bit                exp_hit;
        int                t_req;
        int                t_mem;
        int                t_rsp;
        int                waited;
        line_t             line;
        logic [INSN_W-1:0] exp_insn;
        logic [INSN_W-1:0] insn;
        logic [ADDR_W-1:0] mem_addr;
        exp_hit = model_access(addr);
        line = expected_line(addr);
        exp_insn = addr[2] ? line[LINE_W-1:INSN_W] : line[INSN_W-1:0];
        t_mem = -1;
        t_rsp = -1;
        mem_delay = $urandom % 6 + 1;
        mem_rsp_cyc = -1;
        @(posedge clk);
        i_req <= 1'b1;
        i_req_addr.addr <= addr;
        @(negedge clk);
        t_req = cyc;
        @(posedge clk);
        i_req <= 1'b0;
        waited = 0;
        while (t_rsp < 0 && waited < 20) begin
            @(negedge clk);
            waited++;
            if (o_mem_req) begin
                t_mem = cyc;
                mem_addr = o_mem_req_addr.addr;
            end
            if (o_rsp) begin
                t_rsp = cyc;
                insn = o_rsp_data.insn;
            end
        end
        checks++;
        was_hit = (t_mem < 0);
        if (t_rsp < 0) begin
            $display("No response in %s for address %h", test, addr);
            errors++;
        end else begin
            if (insn !== exp_insn) begin
                report_mismatch(test, "data", exp_insn, insn);
            end
            if (exp_hit) begin
                if (t_mem >= 0) begin
                    $display("Memory request in %s on a hit for address %h", test, addr);
                    errors++;
                end
                if (t_rsp - t_req != 2) begin
                    report_mismatch(test, "hit latency", 2, t_rsp - t_req);
                end
            end else if (t_mem < 0) begin
                $display("No memory request in %s on a miss for address %h", test, addr);
                errors++;
            end else begin
                if (t_mem - t_req != 2) begin
                    report_mismatch(test, "refill request latency", 2, t_mem - t_req);
                end
                if (mem_addr !== {addr[ADDR_W-1:LINE_OFF_W], 3'b000}) begin
                    report_mismatch(test, "refill address",
                                    {addr[ADDR_W-1:LINE_OFF_W], 3'b000}, mem_addr);
                end
                if (t_rsp != mem_rsp_cyc + 1) begin
                    report_mismatch(test, "response after refill", mem_rsp_cyc + 1, t_rsp);
                end
            end
        end
    endtask

    // Memory answers one refill at a time.
    initial begin : memory_model
        line_t rsp_line;
        forever begin
            @(negedge clk);
            if (o_mem_req) begin
                rsp_line = expected_line(o_mem_req_addr.addr);
                repeat (mem_delay) @(posedge clk);
                i_mem_rsp <= 1'b1;
                i_mem_rsp_data.line <= rsp_line;
                @(negedge clk);
                mem_rsp_cyc = cyc;
                @(posedge clk);
                i_mem_rsp <= 1'b0;
            end
        end
    end

    initial begin
        int                err_start;
        bit                hit;
        logic [ADDR_W-1:0] cached [$];
        int                repl_tag [20];
        int                repl_set [20];
        bit                repl_hit [20];
        void'($urandom(32'h29b74eab));
        repl_tag = '{1, 2, 1, 3, 2, 1, 2, 1, 1, 1,
                     1, 1, 1, 1, 1, 4, 1, 2, 4, 2};
        repl_set = '{9, 9, 9, 9, 9, 9, 9, 10, 10, 10,
                     10, 10, 10, 10, 10, 9, 9, 9, 9, 9};
        repl_hit = '{0, 0, 1, 0, 0, 0, 1, 0, 1, 1,
                     1, 1, 1, 1, 1, 0, 1, 0, 0, 1};
        i_rst_n = 1'b0;
        i_req = 1'b0;
        i_req_addr = '0;
        i_flush = 1'b0;
        i_mem_rsp = 1'b0;
        i_mem_rsp_data = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[s][w] = '0;
                m_valid[s][w] = 1'b0;
                m_age[s][w] = 0;
            end
        end

        err_start = errors;
        repeat (16) begin
            @(negedge clk);
            checks++;
            if (o_rsp !== 1'b0 || o_mem_req !== 1'b0) begin
                $display("Response or memory request active during reset");
                errors++;
            end
        end
        @(posedge clk);
        i_rst_n <= 1'b1;
        finish_test("reset", err_start);

        err_start = errors;
        for (int i = 0; i < 4; i++) begin
            fetch_and_check("cold", make_addr(i + 1, 20 + i, i[0]), hit);
            checks++;
            if (hit) begin
                $display("First fetch after reset hit in set %0d", 20 + i);
                errors++;
            end
        end
        finish_test("cold", err_start);

        // Set 10 ages set 9 to saturation so the next miss sees a tie.
        err_start = errors;
        for (int i = 0; i < 20; i++) begin
            fetch_and_check("replacement", make_addr(repl_tag[i], repl_set[i], i[0]), hit);
            checks++;
            if (hit != repl_hit[i]) begin
                report_mismatch("replacement", $sformatf("hit at step %0d", i),
                                repl_hit[i], hit);
            end
        end
        finish_test("replacement", err_start);

        err_start = errors;
        for (int i = 0; i < 60; i++) begin
            fetch_and_check("random", make_addr(5 + $urandom % 4, 2 + $urandom % 3,
                                                $urandom % 2), hit);
        end
        finish_test("random", err_start);

        err_start = errors;
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                if (m_valid[s][w]) begin
                    cached.push_back(make_addr(m_tag[s][w], s, w[0]));
                end
                m_valid[s][w] = 1'b0;
            end
        end
        @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        foreach (cached[i]) begin
            fetch_and_check("flush", cached[i], hit);
            checks++;
            if (hit) begin
                $display("Address %h hit after flush", cached[i]);
                errors++;
            end
        end
        foreach (cached[i]) begin
            fetch_and_check("flush", cached[i], hit);
        end
        finish_test("flush", err_start);

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/cache_geom_pkg.sv
verilog/fetch_bus_pkg.sv
verilog/icache_sram.sv
verilog/icache_way.sv
verilog/icache_age.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
tests/tb_icache.sv
